// ==== design/simt_consts.svh ====
`ifndef SIMT_CONSTS_SVH
`define SIMT_CONSTS_SVH

// Block shape
`define SIMT_WARPS 2
`define SIMT_LANES 4

// Registers per thread, register 0 included
`define SIMT_REGS 8

// Lane data width
`define SIMT_WORD_W 16

// Instruction and data address widths
`define SIMT_PC_W 8
`define SIMT_DADDR_W 8

`endif

// ==== design/simt_isa_pkg.sv ====
`include "simt_consts.svh"

package simt_isa_pkg;

    // Opcodes, 4 bits wide in the instruction word
    typedef enum logic [3:0] {
        ADD   = 4'h0,
        SUB   = 4'h1,
        AND   = 4'h2,
        ADDI  = 4'h3,
        BNEZ  = 4'h4,
        STORE = 4'h5,
        HALT  = 4'h6
    } opcode_t;

    typedef logic [2:0] reg_addr_t;

    typedef logic [`SIMT_PC_W-1:0] pc_t;

    // Low 3 bits of imm are rs2 for register ops,
    // the whole field is a signed immediate otherwise
    typedef struct packed {
        opcode_t   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        logic [5:0] imm;
    } instr_t;

endpackage

// ==== design/simt_core_pkg.sv ====
`include "simt_consts.svh"

package simt_core_pkg;

    // Per-warp execution state
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        STORE_WAIT,
        UPDATE,
        DONE
    } warp_state_t;

    typedef logic [$clog2(`SIMT_WARPS)-1:0] warp_idx_t;

    typedef logic [`SIMT_WORD_W-1:0] word_t;

    // One word per lane of a warp
    typedef word_t lane_vec_t [`SIMT_LANES];

endpackage

// ==== design/warp_fetcher.sv ====
`timescale 1ns/1ps

`include "simt_consts.svh"

module warp_fetcher (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fetch_go,
    input  simt_isa_pkg::pc_t    fetch_pc,
    output logic                 instr_req,
    output simt_isa_pkg::pc_t    instr_addr,
    input  logic                 instr_ack,
    input  simt_isa_pkg::instr_t instr_data,
    output logic                 fetch_done,
    output simt_isa_pkg::instr_t instr
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        RELEASE
    } fetch_state_t;

    fetch_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            instr_req  <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (fetch_go) begin
                        instr_addr <= fetch_pc;
                        instr_req  <= 1'b1;
                        state      <= REQUEST;
                    end
                end
                REQUEST: begin
                    // Data comes with the ack
                    if (instr_ack) begin
                        instr     <= instr_data;
                        instr_req <= 1'b0;
                        state     <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!instr_ack) begin
                        fetch_done <= 1'b1;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== design/warp_scheduler.sv ====
`timescale 1ns/1ps

`include "simt_consts.svh"

module warp_scheduler (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  simt_isa_pkg::pc_t                base_pc,
    input  logic [$clog2(`SIMT_WARPS+1)-1:0] num_warps,
    output logic                             done,
    output logic [`SIMT_WARPS-1:0]           fetch_go,
    output simt_isa_pkg::pc_t                fetch_pc [`SIMT_WARPS],
    input  logic [`SIMT_WARPS-1:0]           fetch_done,
    input  simt_isa_pkg::instr_t             instr [`SIMT_WARPS],
    output simt_core_pkg::warp_idx_t         cur_warp,
    output simt_isa_pkg::opcode_t            op,
    output simt_isa_pkg::reg_addr_t          rd,
    output simt_isa_pkg::reg_addr_t          rs1,
    output simt_isa_pkg::reg_addr_t          rs2,
    output simt_core_pkg::word_t             imm,
    output logic                             exec_en,
    input  simt_core_pkg::word_t             branch_val,
    output logic                             store_go,
    input  logic                             store_done
);

    simt_core_pkg::warp_state_t state [`SIMT_WARPS];
    simt_isa_pkg::pc_t          pc [`SIMT_WARPS];
    simt_isa_pkg::instr_t       cur_instr;
    simt_core_pkg::warp_state_t cur_state;
    simt_core_pkg::warp_idx_t   next_warp;
    logic [`SIMT_WARPS-1:0]     ready;
    logic                       block_idle;
    logic                       all_done;
    logic                       store_busy;
    logic                       launch;
    logic                       rotate;

    // Decode the current warp's held instruction
    assign cur_instr = instr[cur_warp];
    assign cur_state = state[cur_warp];
    assign op        = cur_instr.op;
    assign rd        = cur_instr.rd;
    assign rs1       = cur_instr.rs1;
    assign rs2       = cur_instr.imm[2:0];
    assign imm       = {{(`SIMT_WORD_W - $bits(cur_instr.imm)){cur_instr.imm[5]}}, cur_instr.imm};

    assign exec_en  = (cur_state == simt_core_pkg::EXECUTE);
    // One store in flight at a time, a second one waits in EXECUTE
    assign store_go = exec_en && (op == simt_isa_pkg::STORE) && !store_busy;
    assign fetch_pc = pc;

    always_comb begin
        block_idle = 1'b1;
        all_done   = 1'b1;
        store_busy = 1'b0;
        for (int w = 0; w < `SIMT_WARPS; w++) begin
            ready[w] = (state[w] == simt_core_pkg::DECODE) ||
                       (state[w] == simt_core_pkg::EXECUTE) ||
                       (state[w] == simt_core_pkg::UPDATE);
            if (state[w] != simt_core_pkg::IDLE && state[w] != simt_core_pkg::DONE) begin
                block_idle = 1'b0;
            end
            if (w < num_warps && state[w] != simt_core_pkg::DONE) begin
                all_done = 1'b0;
            end
            if (state[w] == simt_core_pkg::STORE_WAIT) begin
                store_busy = 1'b1;
            end
        end
    end

    // Round robin, first ready warp after the current one
    always_comb begin
        next_warp = cur_warp;
        for (int i = `SIMT_WARPS; i >= 1; i--) begin
            if (ready[(int'(cur_warp) + i) % `SIMT_WARPS]) begin
                next_warp = simt_core_pkg::warp_idx_t'((int'(cur_warp) + i) % `SIMT_WARPS);
            end
        end
    end

    assign launch = start && block_idle;
    assign rotate = (cur_state == simt_core_pkg::UPDATE) ||
                    (cur_state == simt_core_pkg::STORE_WAIT) ||
                    (cur_state == simt_core_pkg::DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_warp <= '0;
            done     <= 1'b0;
            fetch_go <= '0;
            for (int w = 0; w < `SIMT_WARPS; w++) begin
                state[w] <= simt_core_pkg::IDLE;
            end
        end else begin
            fetch_go <= '0;
            done     <= launch ? 1'b0 : all_done;
            if (launch) begin
                cur_warp <= '0;
            end else if (rotate) begin
                cur_warp <= next_warp;
            end
            for (int w = 0; w < `SIMT_WARPS; w++) begin
                if (launch) begin
                    if (w < num_warps) begin
                        state[w]    <= simt_core_pkg::FETCH;
                        pc[w]       <= base_pc;
                        fetch_go[w] <= 1'b1;
                    end else begin
                        state[w] <= simt_core_pkg::IDLE;
                    end
                end else begin
                    case (state[w])
                        simt_core_pkg::FETCH: begin
                            if (fetch_done[w]) begin
                                state[w] <= simt_core_pkg::DECODE;
                            end
                        end
                        simt_core_pkg::DECODE: begin
                            if (cur_warp == w) begin
                                state[w] <= simt_core_pkg::EXECUTE;
                            end
                        end
                        simt_core_pkg::EXECUTE: begin
                            if (cur_warp == w && op != simt_isa_pkg::STORE) begin
                                state[w] <= simt_core_pkg::UPDATE;
                            end else if (cur_warp == w && !store_busy) begin
                                state[w] <= simt_core_pkg::STORE_WAIT;
                            end
                        end
                        simt_core_pkg::STORE_WAIT: begin
                            if (store_done) begin
                                state[w] <= simt_core_pkg::UPDATE;
                            end
                        end
                        simt_core_pkg::UPDATE: begin
                            if (cur_warp == w && op == simt_isa_pkg::HALT) begin
                                state[w] <= simt_core_pkg::DONE;
                            end else if (cur_warp == w) begin
                                // Uniform branch on lane 0
                                if (op == simt_isa_pkg::BNEZ && branch_val != '0) begin
                                    pc[w] <= pc[w] + simt_isa_pkg::pc_t'(imm);
                                end else begin
                                    pc[w] <= pc[w] + 1'b1;
                                end
                                state[w]    <= simt_core_pkg::FETCH;
                                fetch_go[w] <= 1'b1;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

// ==== design/lane_datapath.sv ====
`timescale 1ns/1ps

`include "simt_consts.svh"

module lane_datapath (
    input  logic                      clk,
    input  logic                      reset,
    input  simt_core_pkg::warp_idx_t  cur_warp,
    input  simt_isa_pkg::opcode_t     op,
    input  simt_isa_pkg::reg_addr_t   rd,
    input  simt_isa_pkg::reg_addr_t   rs1,
    input  simt_isa_pkg::reg_addr_t   rs2,
    input  simt_core_pkg::word_t      imm,
    input  logic                      exec_en,
    output simt_core_pkg::lane_vec_t  addr_vec,
    output simt_core_pkg::lane_vec_t  data_vec,
    output simt_core_pkg::word_t      branch_val
);

    // Vector register files of all warps
    simt_core_pkg::word_t     regs [`SIMT_WARPS][`SIMT_REGS][`SIMT_LANES];
    simt_core_pkg::lane_vec_t op_a;
    simt_core_pkg::lane_vec_t op_b;
    simt_core_pkg::lane_vec_t alu_res;
    logic                     alu_op;
    logic                     wr_en;

    // Register 0 is the thread's global index in the block
    function automatic simt_core_pkg::word_t read_reg(simt_isa_pkg::reg_addr_t addr, int lane);
        if (addr == '0) begin
            return simt_core_pkg::word_t'(int'(cur_warp) * `SIMT_LANES + lane);
        end
        return regs[cur_warp][addr][lane];
    endfunction

    always_comb begin
        for (int l = 0; l < `SIMT_LANES; l++) begin
            op_a[l] = read_reg(rs1, l);
            op_b[l] = read_reg(rs2, l);
            case (op)
                simt_isa_pkg::ADD: alu_res[l] = op_a[l] + op_b[l];
                simt_isa_pkg::SUB: alu_res[l] = op_a[l] - op_b[l];
                simt_isa_pkg::AND: alu_res[l] = op_a[l] & op_b[l];
                default:           alu_res[l] = op_a[l] + imm;
            endcase
            addr_vec[l] = op_a[l] + imm;
            data_vec[l] = op_b[l];
        end
    end

    assign branch_val = op_a[0];

    assign alu_op = (op == simt_isa_pkg::ADD) || (op == simt_isa_pkg::SUB) ||
                    (op == simt_isa_pkg::AND) || (op == simt_isa_pkg::ADDI);
    assign wr_en  = exec_en && alu_op && (rd != '0) && !reset;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int l = 0; l < `SIMT_LANES; l++) begin
                regs[cur_warp][rd][l] <= alu_res[l];
            end
        end
    end

endmodule

// ==== design/store_unit.sv ====
`timescale 1ns/1ps

`include "simt_consts.svh"

module store_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      store_go,
    input  simt_core_pkg::lane_vec_t  addr_vec,
    input  simt_core_pkg::lane_vec_t  data_vec,
    output logic                      dmem_req,
    output logic [`SIMT_DADDR_W-1:0]  dmem_addr,
    output simt_core_pkg::word_t      dmem_data,
    input  logic                      dmem_ack,
    output logic                      store_done
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        RELEASE
    } store_state_t;

    store_state_t                     state;
    logic [$clog2(`SIMT_LANES)-1:0]   lane;
    simt_core_pkg::lane_vec_t         addr_q;
    simt_core_pkg::lane_vec_t         data_q;

    // Lane index only moves while req is low
    assign dmem_addr = addr_q[lane][`SIMT_DADDR_W-1:0];
    assign dmem_data = data_q[lane];

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            lane       <= '0;
            dmem_req   <= 1'b0;
            store_done <= 1'b0;
        end else begin
            store_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (store_go) begin
                        addr_q   <= addr_vec;
                        data_q   <= data_vec;
                        lane     <= '0;
                        dmem_req <= 1'b1;
                        state    <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (dmem_ack) begin
                        dmem_req <= 1'b0;
                        state    <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!dmem_ack && lane == ($clog2(`SIMT_LANES))'(`SIMT_LANES - 1)) begin
                        store_done <= 1'b1;
                        state      <= IDLE;
                    end else if (!dmem_ack) begin
                        // Next lane in order
                        lane     <= lane + 1'b1;
                        dmem_req <= 1'b1;
                        state    <= REQUEST;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== design/simt_core.sv ====
`timescale 1ns/1ps

`include "simt_consts.svh"

module simt_core (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  simt_isa_pkg::pc_t                base_pc,
    input  logic [$clog2(`SIMT_WARPS+1)-1:0] num_warps,
    output logic                             done,
    output logic [`SIMT_WARPS-1:0]           instr_req,
    output simt_isa_pkg::pc_t                instr_addr [`SIMT_WARPS],
    input  logic [`SIMT_WARPS-1:0]           instr_ack,
    input  simt_isa_pkg::instr_t             instr_data [`SIMT_WARPS],
    output logic                             dmem_req,
    output logic [`SIMT_DADDR_W-1:0]         dmem_addr,
    output simt_core_pkg::word_t             dmem_data,
    input  logic                             dmem_ack
);

    logic [`SIMT_WARPS-1:0]   fetch_go;
    simt_isa_pkg::pc_t        fetch_pc [`SIMT_WARPS];
    logic [`SIMT_WARPS-1:0]   fetch_done;
    simt_isa_pkg::instr_t     instr [`SIMT_WARPS];
    simt_core_pkg::warp_idx_t cur_warp;
    simt_isa_pkg::opcode_t    op;
    simt_isa_pkg::reg_addr_t  rd;
    simt_isa_pkg::reg_addr_t  rs1;
    simt_isa_pkg::reg_addr_t  rs2;
    simt_core_pkg::word_t     imm;
    logic                     exec_en;
    simt_core_pkg::word_t     branch_val;
    logic                     store_go;
    logic                     store_done;
    simt_core_pkg::lane_vec_t addr_vec;
    simt_core_pkg::lane_vec_t data_vec;

    // One fetcher per warp, running alongside execution
    for (genvar w = 0; w < `SIMT_WARPS; w++) begin : g_fetch
        warp_fetcher u_fetcher (
            .clk        (clk),
            .reset      (reset),
            .fetch_go   (fetch_go[w]),
            .fetch_pc   (fetch_pc[w]),
            .instr_req  (instr_req[w]),
            .instr_addr (instr_addr[w]),
            .instr_ack  (instr_ack[w]),
            .instr_data (instr_data[w]),
            .fetch_done (fetch_done[w]),
            .instr      (instr[w])
        );
    end

    warp_scheduler u_scheduler (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .base_pc    (base_pc),
        .num_warps  (num_warps),
        .done       (done),
        .fetch_go   (fetch_go),
        .fetch_pc   (fetch_pc),
        .fetch_done (fetch_done),
        .instr      (instr),
        .cur_warp   (cur_warp),
        .op         (op),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .imm        (imm),
        .exec_en    (exec_en),
        .branch_val (branch_val),
        .store_go   (store_go),
        .store_done (store_done)
    );

    lane_datapath u_datapath (
        .clk        (clk),
        .reset      (reset),
        .cur_warp   (cur_warp),
        .op         (op),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .imm        (imm),
        .exec_en    (exec_en),
        .addr_vec   (addr_vec),
        .data_vec   (data_vec),
        .branch_val (branch_val)
    );

    store_unit u_store (
        .clk        (clk),
        .reset      (reset),
        .store_go   (store_go),
        .addr_vec   (addr_vec),
        .data_vec   (data_vec),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_data  (dmem_data),
        .dmem_ack   (dmem_ack),
        .store_done (store_done)
    );

endmodule

// ==== test/simt_core_props.sv ====
`timescale 1ns/1ps

`include "simt_consts.svh"

module simt_core_props (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     done,
    input  logic [`SIMT_WARPS-1:0]   instr_req,
    input  simt_isa_pkg::pc_t        instr_addr [`SIMT_WARPS],
    input  logic [`SIMT_WARPS-1:0]   instr_ack,
    input  logic                     dmem_req,
    input  logic [`SIMT_DADDR_W-1:0] dmem_addr,
    input  logic                     dmem_ack
);

    int fail_count = 0;

    // Four-phase fetch handshake, one per warp
    for (genvar w = 0; w < `SIMT_WARPS; w++) begin : g_warp
        a_instr_hold: assert property (@(posedge clk) disable iff (reset)
            instr_req[w] && !instr_ack[w] |=> instr_req[w])
            else begin
                fail_count++;
                $error("instr_req of warp %0d dropped before ack", w);
            end

        a_instr_addr: assert property (@(posedge clk) disable iff (reset)
            instr_req[w] && $past(instr_req[w]) |-> $stable(instr_addr[w]))
            else begin
                fail_count++;
                $error("instr_addr of warp %0d changed during a request", w);
            end

        a_instr_rise: assert property (@(posedge clk) disable iff (reset)
            $rose(instr_req[w]) |-> !$past(instr_ack[w]))
            else begin
                fail_count++;
                $error("instr_req of warp %0d rose while ack was high", w);
            end
    end

    a_dmem_hold: assert property (@(posedge clk) disable iff (reset)
        dmem_req && !dmem_ack |=> dmem_req)
        else begin
            fail_count++;
            $error("dmem_req dropped before ack");
        end

    a_dmem_addr: assert property (@(posedge clk) disable iff (reset)
        dmem_req && $past(dmem_req) |-> $stable(dmem_addr))
        else begin
            fail_count++;
            $error("dmem_addr changed during a request");
        end

    a_dmem_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(dmem_req) |-> !$past(dmem_ack))
        else begin
            fail_count++;
            $error("dmem_req rose while ack was high");
        end

    // Outputs quiet once reset has been seen
    a_reset_low: assert property (@(posedge clk)
        reset |=> !done && instr_req == '0 && !dmem_req)
        else begin
            fail_count++;
            $error("done or a request high after reset");
        end

endmodule

bind simt_core simt_core_props u_props (.*);

// ==== test/simt_core_tb.sv ====
`timescale 1ns/1ps

`include "simt_consts.svh"

module simt_core_tb;

    localparam int ROWS       = 7;
    localparam int MAX_CYCLES = 400 * ROWS;

    // exp holds the data words at addresses 16 to 23
    typedef struct packed {
        logic                       prog;
        simt_isa_pkg::pc_t          base;
        logic [1:0]                 nw;
        logic                       rand_ack;
        simt_core_pkg::word_t [0:7] exp;
    } row_t;

    logic                             clk = 1'b0;
    logic                             reset;
    logic                             start;
    simt_isa_pkg::pc_t                base_pc;
    logic [$clog2(`SIMT_WARPS+1)-1:0] num_warps;
    logic                             done;
    logic [`SIMT_WARPS-1:0]           instr_req;
    simt_isa_pkg::pc_t                instr_addr [`SIMT_WARPS];
    logic [`SIMT_WARPS-1:0]           instr_ack;
    simt_isa_pkg::instr_t             instr_data [`SIMT_WARPS];
    logic                             dmem_req;
    logic [`SIMT_DADDR_W-1:0]         dmem_addr;
    simt_core_pkg::word_t             dmem_data;
    logic                             dmem_ack;

    simt_isa_pkg::instr_t imem [2**`SIMT_PC_W];
    simt_core_pkg::word_t dmem [2**`SIMT_DADDR_W];
    simt_isa_pkg::instr_t progs [2][12];
    int                   prog_len [2];
    row_t                 rows [ROWS];
    int                   i_wait [`SIMT_WARPS];
    int                   d_wait = 0;
    int                   writes = 0;
    int                   cycles = 0;
    integer               seed = 20397;
    logic                 rand_ack = 1'b0;
    logic                 req1_seen = 1'b0;
    logic                 first_seen = 1'b0;
    simt_isa_pkg::pc_t    first_addr;

    simt_core UUT (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .base_pc    (base_pc),
        .num_warps  (num_warps),
        .done       (done),
        .instr_req  (instr_req),
        .instr_addr (instr_addr),
        .instr_ack  (instr_ack),
        .instr_data (instr_data),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_data  (dmem_data),
        .dmem_ack   (dmem_ack)
    );

    always #4 clk = ~clk;

    function automatic simt_isa_pkg::instr_t encode_instr(simt_isa_pkg::opcode_t op,
                                                          int rd, int rs1, int imm);
        simt_isa_pkg::instr_t ins;
        ins.op  = op;
        ins.rd  = 3'(rd);
        ins.rs1 = 3'(rs1);
        ins.imm = 6'(imm);
        return ins;
    endfunction

    // Unused code is HALT with the address in the low bits
    function automatic simt_isa_pkg::instr_t imem_fill(int addr);
        return simt_isa_pkg::instr_t'({simt_isa_pkg::HALT, 4'h0, 8'(addr)});
    endfunction

    function automatic simt_core_pkg::word_t dmem_fill(int addr);
        return simt_core_pkg::word_t'(16'hee00 | addr);
    endfunction

    function automatic int draw_delay();
        if (!rand_ack) begin
            return 0;
        end
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic stop_on_error();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input simt_core_pkg::word_t got,
                              input simt_core_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input simt_isa_pkg::pc_t got,
                              input simt_isa_pkg::pc_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (UUT.u_props.fail_count != 0) begin
            $display("A bound handshake or reset assertion failed");
            stop_on_error();
        end else if (cycles >= MAX_CYCLES) begin
            $display("Timeout: done not seen within %0d cycles", MAX_CYCLES);
            stop_on_error();
        end
    end

    // Memory models answer four-phase requests after a delay
    always @(negedge clk) begin
        for (int w = 0; w < `SIMT_WARPS; w++) begin
            if (w == 1 && instr_req[w]) begin
                req1_seen = 1'b1;
            end
            if (w == 0 && instr_req[w] && !first_seen) begin
                first_addr = instr_addr[w];
                first_seen = 1'b1;
            end
            if (instr_ack[w]) begin
                if (!instr_req[w]) begin
                    instr_ack[w] = 1'b0;
                end
            end else if (instr_req[w]) begin
                if (i_wait[w] == 0) begin
                    instr_data[w] = imem[instr_addr[w]];
                    instr_ack[w]  = 1'b1;
                    i_wait[w]     = draw_delay();
                end else begin
                    i_wait[w]--;
                end
            end
        end
        if (dmem_ack) begin
            if (!dmem_req) begin
                dmem_ack = 1'b0;
            end
        end else if (dmem_req) begin
            if (d_wait == 0) begin
                dmem[dmem_addr] = dmem_data;
                writes++;
                dmem_ack = 1'b1;
                d_wait   = draw_delay();
            end else begin
                d_wait--;
            end
        end
    end

    task automatic run_row(int r);
        row_t row;
        row = rows[r];
        for (int a = 0; a < 256; a++) begin
            imem[a] = imem_fill(a);
            dmem[a] = dmem_fill(a);
        end
        for (int i = 0; i < prog_len[row.prog]; i++) begin
            imem[simt_isa_pkg::pc_t'(row.base + i)] = progs[row.prog][i];
        end
        rand_ack   = row.rand_ack;
        writes     = 0;
        req1_seen  = 1'b0;
        first_seen = 1'b0;
        @(negedge clk);
        base_pc   = row.base;
        num_warps = row.nw;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag("done after start", done, 1'b0);
        while (!done) begin
            @(negedge clk);
        end
        for (int a = 0; a < 8; a++) begin
            check_word($sformatf("dmem[%0d]", 16 + a), dmem[16 + a], row.exp[a]);
        end
        check_word("write count", simt_core_pkg::word_t'(writes),
                   simt_core_pkg::word_t'(`SIMT_LANES * row.nw));
        check_addr("first instr_addr", first_addr, row.base);
        check_flag("instr_req[1] seen", req1_seen, row.nw == 2);
        // Done holds until the next start
        repeat (4) begin
            @(negedge clk);
            check_flag("done", done, 1'b1);
        end
    endtask

    initial begin
        simt_core_pkg::word_t [0:7] exp_a1;
        simt_core_pkg::word_t [0:7] exp_a2;
        simt_core_pkg::word_t [0:7] exp_b1;
        simt_core_pkg::word_t [0:7] exp_b2;

        reset     = 1'b1;
        start     = 1'b0;
        base_pc   = '0;
        num_warps = 1;
        instr_ack = '0;
        dmem_ack  = 1'b0;
        for (int w = 0; w < `SIMT_WARPS; w++) begin
            instr_data[w] = '0;
            i_wait[w]     = 0;
        end

        // Store each thread index at 16 + index
        progs[0][0] = encode_instr(simt_isa_pkg::ADDI, 1, 0, 16);
        progs[0][1] = encode_instr(simt_isa_pkg::STORE, 0, 1, 0);
        progs[0][2] = encode_instr(simt_isa_pkg::HALT, 0, 0, 0);
        prog_len[0] = 3;

        // Add 3 five times in a countdown loop, then store at 16 + index
        progs[1][0] = encode_instr(simt_isa_pkg::SUB, 3, 0, 0);
        progs[1][1] = encode_instr(simt_isa_pkg::ADDI, 2, 3, 5);
        progs[1][2] = encode_instr(simt_isa_pkg::ADDI, 1, 0, 0);
        progs[1][3] = encode_instr(simt_isa_pkg::ADDI, 1, 1, 3);
        progs[1][4] = encode_instr(simt_isa_pkg::ADDI, 2, 2, -1);
        progs[1][5] = encode_instr(simt_isa_pkg::BNEZ, 0, 2, -2);
        progs[1][6] = encode_instr(simt_isa_pkg::ADDI, 5, 0, -1);
        progs[1][7] = encode_instr(simt_isa_pkg::STORE, 0, 5, 17);
        progs[1][8] = encode_instr(simt_isa_pkg::HALT, 0, 0, 0);
        prog_len[1] = 9;

        exp_a1 = '{16'h0000, 16'h0001, 16'h0002, 16'h0003,
                   16'hee14, 16'hee15, 16'hee16, 16'hee17};
        exp_a2 = '{16'h0000, 16'h0001, 16'h0002, 16'h0003,
                   16'h0004, 16'h0005, 16'h0006, 16'h0007};
        exp_b1 = '{16'h000f, 16'h0010, 16'h0011, 16'h0012,
                   16'hee14, 16'hee15, 16'hee16, 16'hee17};
        exp_b2 = '{16'h000f, 16'h0010, 16'h0011, 16'h0012,
                   16'h0013, 16'h0014, 16'h0015, 16'h0016};

        // prog, base_pc, num_warps, random acks, expected words
        rows[0] = '{1'b0, 8'h20, 2'd1, 1'b0, exp_a1};
        rows[1] = '{1'b0, 8'h00, 2'd2, 1'b0, exp_a2};
        rows[2] = '{1'b1, 8'h10, 2'd1, 1'b0, exp_b1};
        rows[3] = '{1'b0, 8'h40, 2'd1, 1'b1, exp_a1};
        rows[4] = '{1'b0, 8'h08, 2'd2, 1'b1, exp_a2};
        rows[5] = '{1'b1, 8'h30, 2'd1, 1'b1, exp_b1};
        rows[6] = '{1'b1, 8'h50, 2'd2, 1'b1, exp_b2};

        repeat (3) @(negedge clk);
        reset = 1'b0;

        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end

        if (UUT.u_props.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", UUT.u_props.fail_count);
            stop_on_error();
        end
    end

endmodule

// ==== simt_core.f ====
+incdir+design
design/simt_isa_pkg.sv
design/simt_core_pkg.sv
design/warp_fetcher.sv
design/warp_scheduler.sv
design/lane_datapath.sv
design/store_unit.sv
design/simt_core.sv
test/simt_core_props.sv
test/simt_core_tb.sv

// ==== Bender.yml ====
package:
  name: simt_core

sources:
  - include_dirs:
      - design
    files:
      - design/simt_isa_pkg.sv
      - design/simt_core_pkg.sv
      - design/warp_fetcher.sv
      - design/warp_scheduler.sv
      - design/lane_datapath.sv
      - design/store_unit.sv
      - design/simt_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/simt_core_props.sv
      - test/simt_core_tb.sv
